//--- lsu.f
logic/lsu_pkg.sv
logic/lsu_addr_check.sv
logic/lsu_store_align.sv
logic/lsu_ctrl.sv
logic/lsu_load_align.sv
logic/lsu_top.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv

//--- Makefile
# Verilator lint and simulation of the load-store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_STR)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/lsu_tb.sv
// one access in flight at a time; rvalid always one cycle after grant; no bus errors driven
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*;
();

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;  // watchdog budget per test

  logic       clk, rst_n;
  logic       data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i, ex_valid_i;
  data_type_e data_type_ex_i;
  sign_ext_e  data_sign_ext_ex_i;
  word_t      data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i, data_rdata_i;
  offs_t      data_reg_offset_ex_i;
  logic       data_gnt_i, data_rvalid_i, data_err_i;
  word_t      data_rdata_ex_o, data_addr_o, data_wdata_o;
  logic       data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o, data_req_o, data_we_o;
  be_t        data_be_o;

  int     errors, checks, tests_done;
  integer seed;
  string  cur_test;   // name of the running test
  be_t    got_be;     // sampled at grant
  word_t  got_wdata;
  word_t  got_addr;
  logic   got_misal;
  word_t  got_rdata;  // sampled at rvalid

  lsu_top i_lsu_top (.*);

  always #50 clk = ~clk;

  ////////////////////
  // compare and model
  ////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // store enables lane by lane for the first or the second part
  function automatic be_t lane_mask(input data_type_e t, input int off, input logic second);
    be_t m;
    for (int l = 0; l < LANES; l++)
      case (t)
        DT_WORD: m[l] = second ? (l < off) : (l >= off);
        DT_HALF: m[l] = second ? (l == 0) : ((l == off) || (l == off + 1));  // lane 4 does not exist
        default: m[l] = (l == off);
      endcase
    return m;
  endfunction

  function automatic word_t rotl_bytes(input word_t w, input int r);
    logic [63:0] d;
    d = {w, w};
    return d[32 - 8*(r & 3) +: 32];  // r taken modulo 4
  endfunction

  // pair holds the second word above the first and bytes count from the offset
  function automatic word_t load_value(input logic [63:0] pair, input int off,
                                       input data_type_e t, input sign_ext_e m);
    logic [63:0] sel;
    logic        top;
    word_t       r;
    sel = pair >> (8*off);
    top = (t == DT_HALF) ? sel[15] : sel[7];
    if (m == SE_ZERO)
      top = 1'b0;
    else if (m == SE_ONES)
      top = 1'b1;
    case (t)
      DT_WORD: r = sel[31:0];
      DT_HALF: r = {{16{top}}, sel[15:0]};
      default: r = {{24{top}}, sel[7:0]};
    endcase
    return r;
  endfunction

  ////////////////////
  // bus driving
  ////////////////////

  task automatic step_cycle();
    @(posedge clk);
    #5;
  endtask

  // one request with a random grant gap and rvalid in the next cycle
  task automatic run_access(input logic we, input data_type_e t, input sign_ext_e m,
                            input word_t addr, input word_t wd, input offs_t roff,
                            input logic second, input word_t rd);
    int gap;
    gap = ($random(seed) & 32'h7fff_ffff) % 3;
    data_we_ex_i         = we;
    data_type_ex_i       = t;
    data_sign_ext_ex_i   = m;
    data_wdata_ex_i      = wd;
    data_reg_offset_ex_i = roff;
    operand_a_ex_i       = {addr[31:2], 2'b00};  // word base
    operand_b_ex_i       = {30'd0, addr[1:0]};   // byte offset through the adder
    addr_useincr_ex_i    = 1'b1;
    data_misaligned_ex_i = second;
    data_req_ex_i        = 1'b1;
    repeat (gap)
    begin
      @(negedge clk);
      check_bit({cur_test, " req before grant"}, 1'b1, data_req_o);
      check_bit({cur_test, " ready_ex before grant"}, 1'b0, lsu_ready_ex_o);
      step_cycle();
    end
    data_gnt_i = 1'b1;
    @(negedge clk);
    check_bit({cur_test, " req at grant"}, 1'b1, data_req_o);
    check_bit({cur_test, " we at grant"}, we, data_we_o);
    got_be    = data_be_o;
    got_wdata = data_wdata_o;
    got_addr  = data_addr_o;
    got_misal = data_misaligned_o;
    step_cycle();
    data_gnt_i           = 1'b0;
    data_req_ex_i        = 1'b0;
    data_misaligned_ex_i = second | got_misal;  // execute heads into the second part
    data_rvalid_i        = 1'b1;
    data_rdata_i         = rd;
    @(negedge clk);
    got_rdata = data_rdata_ex_o;  // bypass value
    step_cycle();
    data_rvalid_i = 1'b0;
  endtask

  task automatic report_test(input string name, input int e0);
    tests_done++;
    $display("%s: %s", name, (errors == e0) ? "pass" : "fail");
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_bit("reset busy", 1'b0, busy_o);
    check_bit("reset req", 1'b0, data_req_o);
    check_bit("reset ready_ex", 1'b1, lsu_ready_ex_o);
    check_bit("reset ready_wb", 1'b1, lsu_ready_wb_o);
    step_cycle();
    report_test("reset_state", e0);
  endtask

  task automatic test_store_sizes();
    int    e0;
    word_t wd;
    logic  split;
    e0       = errors;
    cur_test = "store_sizes";
    wd       = 32'hd4c3_b2a1;
    for (int t = 0; t < 3; t++)
      for (int off = 0; off < 4; off++)
      begin
        split = ((t == 0) && (off != 0)) || ((t == 1) && (off == 3));  // crosses a word
        run_access(1'b1, data_type_e'(t), SE_ZERO, 32'h0000_2000 + off, wd, 2'd0, 1'b0, '0);
        check_bit("store_sizes split", split, got_misal);
        check_be("store_sizes be", lane_mask(data_type_e'(t), off, 1'b0), got_be);
        check_word("store_sizes data", rotl_bytes(wd, off), got_wdata);
        if (split)
        begin
          run_access(1'b1, data_type_e'(t), SE_ZERO, 32'h0000_2004 + off, wd, 2'd0, 1'b1, '0);
          check_be("store_sizes second be", lane_mask(data_type_e'(t), off, 1'b1), got_be);
          check_word("store_sizes second data", rotl_bytes(wd, off), got_wdata);
        end
      end
    report_test("store_sizes", e0);
  endtask

  task automatic test_store_reg_offset();
    int e0;
    e0       = errors;
    cur_test = "store_reg_offset";
    run_access(1'b1, DT_BYTE, SE_ZERO, 32'h0000_3001, 32'h4433_2211, 2'd2, 1'b0, '0);
    check_be("store_reg_offset be", 4'b0010, got_be);
    check_word("store_reg_offset data", rotl_bytes(32'h4433_2211, 1 - 2), got_wdata);
    run_access(1'b1, DT_HALF, SE_ZERO, 32'h0000_3002, 32'h4433_2211, 2'd1, 1'b0, '0);
    check_be("store_reg_offset be", 4'b1100, got_be);
    check_word("store_reg_offset data", rotl_bytes(32'h4433_2211, 2 - 1), got_wdata);
    report_test("store_reg_offset", e0);
  endtask

  task automatic test_load_extend();
    int    e0;
    word_t rd;
    e0       = errors;
    cur_test = "load_extend";
    rd       = 32'h7fe5_9a41;  // lanes mix set and clear top bits
    for (int m = 0; m < 3; m++)
    begin
      for (int off = 0; off < 4; off++)
      begin
        run_access(1'b0, DT_BYTE, sign_ext_e'(m), 32'h0000_4000 + off, '0, '0, 1'b0, rd);
        check_word("load_extend byte",
                   load_value({32'd0, rd}, off, DT_BYTE, sign_ext_e'(m)), got_rdata);
      end
      for (int off = 0; off < 4; off += 2)
      begin
        run_access(1'b0, DT_HALF, sign_ext_e'(m), 32'h0000_4000 + off, '0, '0, 1'b0, rd);
        check_word("load_extend half",
                   load_value({32'd0, rd}, off, DT_HALF, sign_ext_e'(m)), got_rdata);
      end
    end
    report_test("load_extend", e0);
  endtask

  task automatic test_split_loads();
    int    e0;
    word_t w1, w2;
    e0       = errors;
    cur_test = "split_loads";
    w1       = 32'h4433_2211;
    w2       = 32'h8877_6655;
    run_access(1'b0, DT_WORD, SE_ZERO, 32'h0000_5001, '0, '0, 1'b0, w1);
    check_bit("split_loads word first part", 1'b1, got_misal);
    run_access(1'b0, DT_WORD, SE_ZERO, 32'h0000_5005, '0, '0, 1'b1, w2);
    check_bit("split_loads word second part", 1'b0, got_misal);
    check_word("split_loads word addr", 32'h0000_5005, got_addr);
    check_word("split_loads word data", load_value({w2, w1}, 1, DT_WORD, SE_ZERO), got_rdata);
    w1 = 32'hc3b2_a190;
    w2 = 32'h7766_55f4;
    run_access(1'b0, DT_HALF, SE_SIGN, 32'h0000_6003, '0, '0, 1'b0, w1);
    check_bit("split_loads half first part", 1'b1, got_misal);
    run_access(1'b0, DT_HALF, SE_SIGN, 32'h0000_6007, '0, '0, 1'b1, w2);
    check_bit("split_loads half second part", 1'b0, got_misal);
    check_word("split_loads half data", load_value({w2, w1}, 3, DT_HALF, SE_SIGN), got_rdata);
    report_test("split_loads", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int wait_cycles;
    e0 = errors;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = DT_WORD;
    data_misaligned_ex_i = 1'b0;
    operand_a_ex_i       = 32'h0000_7000;
    operand_b_ex_i       = '0;
    data_req_ex_i        = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_bit("backpressure req", 1'b1, data_req_o);
      check_bit("backpressure ready_ex", 1'b0, lsu_ready_ex_o);
      check_bit("backpressure busy", 1'b1, busy_o);
      step_cycle();
    end
    data_gnt_i = 1'b1;
    ex_valid_i = 1'b0;  // execute stalls as the grant lands
    step_cycle();
    data_gnt_i    = 1'b0;
    data_req_ex_i = 1'b0;
    data_rvalid_i = 1'b1;
    data_rdata_i  = 32'h1357_9bdf;
    step_cycle();
    data_rvalid_i = 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      check_bit("backpressure stalled busy", 1'b1, busy_o);
      step_cycle();
    end
    ex_valid_i  = 1'b1;
    wait_cycles = 0;
    @(negedge clk);
    while (busy_o && wait_cycles < 8)
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (busy_o)
    begin
      errors++;
      $display("busy stayed high after the execute stage resumed");
    end
    check_bit("backpressure ready_ex after stall", 1'b1, lsu_ready_ex_o);
    step_cycle();
    report_test("backpressure", e0);
  endtask

  ////////////////////
  // sequence
  ////////////////////

  initial
  begin
    clk                  = 1'b0;
    rst_n                = 1'b0;
    seed                 = 32'hd433_8961;
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = DT_WORD;
    data_sign_ext_ex_i   = SE_ZERO;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = '0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i           = 1'b1;
    data_gnt_i           = 1'b0;
    data_rvalid_i        = 1'b0;
    data_err_i           = 1'b0;
    data_rdata_i         = '0;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    test_reset_state();
    test_store_sizes();
    test_store_reg_offset();
    test_load_extend();
    test_split_loads();
    test_backpressure();
    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog sized from the per-test budget
  initial
  begin
    repeat (16 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog expired, a test stopped making progress");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- tb/lsu_assertions.sv
// controller protocol checks; the address check reads data_addr_o of the enclosing lsu_top
`timescale 1ns/1ps

module lsu_assertions import lsu_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input lsu_state_e state_q,
  input logic       data_req_o,
  input logic       data_gnt_i,
  input logic       data_rvalid_i,
  input word_t      addr_i          // memory address from the top level
);

  // a response only ever belongs to a granted access
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ST_IDLE) |-> !data_rvalid_i)
    else $error("rvalid seen while the controller is idle");

  // overlap only when the old response retires in the same cycle
  a_gnt_needs_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    ((state_q == ST_WAIT_RVALID) && data_gnt_i) |-> data_rvalid_i)
    else $error("grant in wait state without the pending rvalid");

  a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown(addr_i))
    else $error("address unknown during a request");

endmodule

bind lsu_ctrl lsu_assertions i_lsu_assertions (
  .clk, .rst_n, .state_q, .data_req_o, .data_gnt_i, .data_rvalid_i,
  .addr_i (lsu_top.data_addr_o)
);

//--- logic/lsu_top.sv
// execute stage must hold its inputs stable until granted and reissue split accesses itself
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // execute stage
  input  logic       data_req_ex_i,
  input  logic       data_we_ex_i,
  input  data_type_e data_type_ex_i,
  input  sign_ext_e  data_sign_ext_ex_i,
  input  word_t      data_wdata_ex_i,
  input  offs_t      data_reg_offset_ex_i,
  input  word_t      operand_a_ex_i,
  input  word_t      operand_b_ex_i,
  input  logic       addr_useincr_ex_i,
  input  logic       data_misaligned_ex_i,
  input  logic       ex_valid_i,
  output word_t      data_rdata_ex_o,
  output logic       data_misaligned_o,
  output logic       lsu_ready_ex_o,
  output logic       lsu_ready_wb_o,
  output logic       busy_o,
  // memory port
  output logic       data_req_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  logic       data_err_i,
  output word_t      data_addr_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_wdata_o,
  input  word_t      data_rdata_i
);

  logic split_first;  // either part of a split pair in flight

  assign data_we_o = data_we_ex_i;  // write flag goes out unchanged

  lsu_addr_check i_addr_check (
    .operand_a_ex_i, .operand_b_ex_i, .addr_useincr_ex_i, .data_req_ex_i,
    .data_type_ex_i, .data_misaligned_ex_i, .data_addr_o, .data_misaligned_o,
    .split_first_o (split_first)
  );

  lsu_store_align i_store_align (
    .data_addr_i (data_addr_o), .data_type_ex_i, .data_misaligned_ex_i,
    .data_wdata_ex_i, .data_reg_offset_ex_i, .data_be_o, .data_wdata_o
  );

  lsu_ctrl i_ctrl (
    .clk, .rst_n, .data_req_ex_i, .data_gnt_i, .data_rvalid_i, .data_err_i,
    .ex_valid_i, .data_req_o, .lsu_ready_ex_o, .lsu_ready_wb_o, .busy_o
  );

  lsu_load_align i_load_align (
    .clk, .rst_n, .data_gnt_i, .data_rvalid_i, .data_rdata_i,
    .data_addr_i (data_addr_o), .data_type_ex_i, .data_sign_ext_ex_i, .data_we_ex_i,
    .split_first_i (split_first), .data_rdata_ex_o
  );

endmodule

//--- logic/lsu_load_align.sv
// read data holds its last buffered value after rvalid; buffer content is undefined before the first load
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  word_t      data_rdata_i,        // memory word
  input  word_t      data_addr_i,         // effective address of the granted access
  input  data_type_e data_type_ex_i,
  input  sign_ext_e  data_sign_ext_ex_i,
  input  logic       data_we_ex_i,
  input  logic       split_first_i,       // keep the raw word for a split pair
  output word_t      data_rdata_ex_o      // to the register file
);

  data_type_e type_q;      // attributes of the access in flight
  offs_t      offs_q;
  sign_ext_e  sign_ext_q;
  logic       we_q;

  word_t rdata_q;          // buffered read data
  word_t joined;           // lanes gathered from new and buffered words
  word_t rdata_ext;        // extended result
  logic  spans;            // access straddles two words
  logic  fill;             // extension bit

  // attributes are latched at grant, response comes later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= DT_WORD;
      offs_q     <= '0;
      sign_ext_q <= SE_ZERO;
      we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q     <= data_type_ex_i;
      offs_q     <= data_addr_i[OFFS_W-1:0];
      sign_ext_q <= data_sign_ext_ex_i;
      we_q       <= data_we_ex_i;
    end
  end

  assign spans = ((type_q == DT_WORD) && (offs_q != '0)) ||
                 ((type_q == DT_HALF) && (offs_q == 2'd3));

  ////////////////////
  // lane select
  ////////////////////

  // result lane l is memory byte offs_q + l, past lane 3 it comes from the next word
  always_comb
  begin
    logic [OFFS_W:0] src;
    for (int l = 0; l < LANES; l++)
    begin
      src = {1'b0, offs_q} + (OFFS_W+1)'(l);
      if (src[OFFS_W] || !spans)
        joined[8*l +: 8] = data_rdata_i[8*src[OFFS_W-1:0] +: 8];
      else
        joined[8*l +: 8] = rdata_q[8*src[OFFS_W-1:0] +: 8];  // lower part from first word
    end
  end

  // extension
  always_comb
  begin
    case (sign_ext_q)
      SE_ZERO: fill = 1'b0;
      SE_ONES: fill = 1'b1;
      default: fill = (type_q == DT_HALF) ? joined[15] : joined[7];  // sign, also for 3
    endcase
    case (type_q)
      DT_WORD: rdata_ext = joined;
      DT_HALF: rdata_ext = {{16{fill}}, joined[15:0]};
      default: rdata_ext = {{24{fill}}, joined[7:0]};
    endcase
  end

  // raw word for the first part of a split, final value otherwise
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
      rdata_q <= split_first_i ? data_rdata_i : rdata_ext;
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // bypass in the rvalid cycle

endmodule

//--- logic/lsu_ctrl.sv
// memory must return exactly one rvalid per grant, never in the grant cycle
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // access wanted by execute stage
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  input  logic ex_valid_i,      // execute stage moves on this cycle
  output logic data_req_o,
  output logic lsu_ready_ex_o,  // execute stage may advance
  output logic lsu_ready_wb_o,  // writeback stage may advance
  output logic busy_o
);

  lsu_state_e state_q, state_d;
  logic       issue_window;  // a new request may go out this cycle

  // idle, or the outstanding response arrives now so the port frees up
  assign issue_window = (state_q == ST_IDLE) ||
                        ((state_q == ST_WAIT_RVALID) && data_rvalid_i);

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      ST_IDLE: ;  // issue path below
      ST_WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;    // writeback waits for the response
        if (data_rvalid_i)
          state_d = ST_IDLE;               // may be overridden by a new grant
      end
      ST_WAIT_RVALID_EX_STALL:
      begin
        // no new request while execute is stalled
        if (data_rvalid_i)
          state_d = ex_valid_i ? ST_IDLE : ST_IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = ST_WAIT_RVALID;        // stall lifted before the response
      end
      ST_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = ST_IDLE;
      end
    endcase

    // request straight from execute, zero cycles
    if (issue_window)
    begin
      data_req_o = data_req_ex_i;
      if (data_req_ex_i)
      begin
        lsu_ready_ex_o = data_gnt_i | data_err_i;  // hold execute until accepted or failed
        if (data_gnt_i)
          state_d = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_EX_STALL;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // anything outstanding or on the way out
  assign busy_o = (state_q != ST_IDLE) || data_req_o;

endmodule

//--- logic/lsu_store_align.sv
// second part of a split store expects the same byte offset as the first, one word higher
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*;
(
  input  word_t      data_addr_i,           // effective address
  input  data_type_e data_type_ex_i,
  input  logic       data_misaligned_ex_i,  // second part of a split store
  input  word_t      data_wdata_ex_i,       // register value
  input  offs_t      data_reg_offset_ex_i,  // byte offset of the value in the register
  output be_t        data_be_o,
  output word_t      data_wdata_o           // rotated onto the memory lanes
);

  offs_t addr_offs;  // lane of the first byte in memory
  offs_t rot;        // left rotation in bytes

  assign addr_offs = data_addr_i[OFFS_W-1:0];
  assign rot       = addr_offs - data_reg_offset_ex_i;  // wraps modulo 4

  ////////////////////
  // byte enables
  ////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      DT_WORD:
      begin
        if (!data_misaligned_ex_i)
          data_be_o = 4'b1111 << addr_offs;           // offset lane and up
        else
          data_be_o = (4'b0001 << addr_offs) - 4'd1;  // lanes below offset
      end
      DT_HALF:
      begin
        if (!data_misaligned_ex_i)
          data_be_o = 4'b0011 << addr_offs;  // upper lane drops off at offset 3
        else
          data_be_o = 4'b0001;               // spilled byte lands in lane 0
      end
      default: data_be_o = 4'b0001 << addr_offs;  // single byte
    endcase
  end

  ////////////////////
  // data rotation
  ////////////////////

  // memory lane l takes register byte (l - rot) mod 4
  always_comb
  begin
    offs_t src;
    for (int l = 0; l < LANES; l++)
    begin
      src = offs_t'(l) - rot;
      data_wdata_o[8*l +: 8] = data_wdata_ex_i[8*src +: 8];
    end
  end

endmodule

//--- logic/lsu_addr_check.sv
// effective address is not range checked; only word and halfword accesses can be split
`timescale 1ns/1ps

module lsu_addr_check import lsu_pkg::*;
(
  input  word_t      operand_a_ex_i,        // base
  input  word_t      operand_b_ex_i,        // offset
  input  logic       addr_useincr_ex_i,     // base plus offset when set
  input  logic       data_req_ex_i,
  input  data_type_e data_type_ex_i,
  input  logic       data_misaligned_ex_i,  // second part of a split access
  output word_t      data_addr_o,
  output logic       data_misaligned_o,     // first part needs a second access
  output logic       split_first_o          // either part of a split pair
);

  offs_t addr_offs;  // byte offset of the current access

  // address adder, base only when the increment is off
  assign data_addr_o = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_offs   = data_addr_o[OFFS_W-1:0];

  // split detection, never flagged on the second part itself
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i)
    begin
      case (data_type_ex_i)
        DT_WORD: data_misaligned_o = (addr_offs != '0);      // any nonzero offset
        DT_HALF: data_misaligned_o = (addr_offs == 2'd3);    // top lane only
        default: data_misaligned_o = 1'b0;                   // bytes always fit
      endcase
    end
  end

  // load aligner keeps the raw word while either part is in flight
  assign split_first_o = data_misaligned_o | data_misaligned_ex_i;

endmodule

//--- logic/lsu_pkg.sv
// 32-bit words with four byte lanes only; the widths below are fixed by the byte-lane logic
package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int WORD_W = 32;  // data and address width
  localparam int LANES  = 4;   // byte lanes per word
  localparam int OFFS_W = 2;   // byte offset inside a word

  typedef logic [WORD_W-1:0] word_t;  // data or address word
  typedef logic [LANES-1:0]  be_t;    // byte-enable mask, one bit per lane
  typedef logic [OFFS_W-1:0] offs_t;  // byte offset

  ////////////////////
  // encodings
  ////////////////////

  // access size, 3 is treated as a byte
  typedef enum logic [1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2
  } data_type_e;

  // load extension mode, 3 is treated as sign
  typedef enum logic [1:0] {
    SE_ZERO = 2'd0,  // zero fill
    SE_SIGN = 2'd1,  // copy top bit
    SE_ONES = 2'd2   // ones fill
  } sign_ext_e;

  // memory protocol controller
  typedef enum logic [1:0] {
    ST_IDLE,                  // free, may issue
    ST_WAIT_RVALID,           // granted, waiting on response
    ST_WAIT_RVALID_EX_STALL,  // granted while execute stage stalled
    ST_IDLE_EX_STALL          // response in, execute stage still stalled
  } lsu_state_e;

endpackage
